// ==== sim.f ====
+incdir+test
source/video_pkg.sv
source/video_regs.sv
source/timing_gen.sv
source/pattern_gen.sv
source/video_top.sv
test/video_tb.sv

// ==== test/axil_bfm.svh ====
`ifndef axil_bfm_svh
`define axil_bfm_svh

// AXI4-Lite master tasks driven on the falling edge
// A random stall before bready or rready exercises response back-pressure

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic [1:0] resp);
    int stall;
    stall = pick_range(0, 2);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) begin
        @(negedge clk);
    end
    check_value(wready, 1, "wready with awready");
    @(negedge clk);  // Accepted at the posedge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
        @(negedge clk);
    end
    repeat (stall) @(negedge clk);
    check_value(bvalid, 1, "bvalid held while bready low");
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    int stall;
    stall = pick_range(0, 2);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) begin
        @(negedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) begin
        @(negedge clk);
    end
    repeat (stall) @(negedge clk);
    check_value(rvalid, 1, "rvalid held while rready low");
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
endtask

`endif

// ==== test/video_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module video_tb import video_pkg::*;;

    localparam int num_sets       = 6;   // Patterns 0 to 4 plus one unused code
    localparam int frames_per_set = 3;
    localparam int max_frame      = 48 * 20;
    localparam int timeout_cycles = num_sets * frames_per_set * max_frame * 2;

    logic        clk;
    logic        reset;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        hs_out;
    logic        vs_out;
    logic        de_out;
    logic [35:0] pixel;

    logic [31:0] seed = 32'h79471d99;
    int          errors = 0;
    int          cycles = 0;
    int          vs_rises = 0;
    logic        vs_prev = 1'b0;

    // Model of the programmed frame
    int          m_h_total;
    int          m_h_sync;
    int          m_h_bp;
    int          m_h_fp;
    int          m_v_total;
    int          m_v_sync;
    int          m_v_bp;
    int          m_v_fp;
    int          m_aw;
    int          m_ah;
    logic [2:0]  m_pattern;
    logic [23:0] m_arg;

    video_top #(.x_bits(12), .y_bits(12)) video_top_inst (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .hs_out  (hs_out),
        .vs_out  (vs_out),
        .de_out  (de_out),
        .pixel   (pixel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int pick_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'((r >> 8) % (hi - lo + 1));
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    `include "axil_bfm.svh"

    task automatic write_okay(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        write_reg(addr, data, 4'hF, resp);
        check_value(resp, 2'b00, "write response");
    endtask

    // Expected colour with each 8-bit channel at the top of its 12-bit lane
    function automatic logic [35:0] expect_pixel(input int px, input int py);
        logic [7:0]  r;
        logic [7:0]  g;
        logic [7:0]  b;
        logic [19:0] acc;
        r   = 8'h00;
        acc = 20'(px * int'(m_arg[19:0]));  // Ramp shows the sum before this pixel adds
        case (m_pattern)
            pat_solid:   r = m_arg[23:16];
            pat_border:  r = (px == 0 || py == 0 || px == m_aw - 1 || py == m_ah - 1)
                             ? 8'hFF : 8'h00;
            pat_moire_x: r = (px % 2 == 1) ? 8'hFF : 8'h00;
            pat_moire_y: r = (py % 2 == 1) ? 8'hFF : 8'h00;
            pat_ramp:    r = acc[19:12];
            default:     r = 8'h00;
        endcase
        g = (m_pattern == pat_solid) ? m_arg[15:8] : r;
        b = (m_pattern == pat_solid) ? m_arg[7:0] : r;
        return {r, 4'h0, g, 4'h0, b, 4'h0};
    endfunction

    task automatic test_registers();
        logic [31:0] model [0:5];
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        int          idx;
        for (int i = 0; i < 6; i++) begin
            model[i] = '0;
        end
        for (int n = 0; n < 14; n++) begin
            idx  = pick_range(0, 5);
            data = next_rand();
            strb = 4'(next_rand() >> 12);
            if (idx == 0) begin
                data[0] = 1'b0;  // Keep video off
            end
            write_reg(8'(idx * 4), data, strb, resp);
            check_value(resp, 2'b00, "write response");
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        write_reg(8'h1C, next_rand(), 4'hF, resp);
        check_value(resp, 2'b10, "unmapped write response");
        write_reg(8'h06, next_rand(), 4'hF, resp);  // Misaligned
        check_value(resp, 2'b10, "misaligned write response");
        write_reg(reg_status, next_rand(), 4'hF, resp);
        check_value(resp, 2'b00, "status write response");
        read_reg(8'h1C, data, resp);
        check_value(resp, 2'b10, "unmapped read response");
        check_value(data, 0, "unmapped read data");
        read_reg(reg_status, data, resp);
        check_value(data, 0, "status after ignored write");
        for (int i = 0; i < 6; i++) begin
            read_reg(8'(i * 4), data, resp);
            check_value(resp, 2'b00, "read response");
            check_value(data, model[i], "register readback");
        end
    endtask

    // Steps to the next vs rise and optionally flags any de on the way
    task automatic wait_vs_rise(input logic prev_init, input bit no_de);
        logic prev;
        prev = prev_init;
        while (!(vs_out && !prev)) begin
            if (no_de) begin
                check_value(de_out, 0, "de before first vs after enable");
            end
            prev = vs_out;
            @(negedge clk);
        end
    endtask

    // Measures one frame from vs rise to vs rise and tracks x and y from de edges
    task automatic measure_frame();
        int   cyc;
        int   hs_rise;
        int   hs_len;
        int   vs_high;
        int   px;
        int   py;
        logic hs_q;
        logic de_q;
        logic vs_q;
        bit   done;
        cyc = 0;
        hs_rise = 0;
        hs_len = 0;
        vs_high = 0;
        px = 0;
        py = 0;
        hs_q = 1'b0;
        de_q = 1'b0;
        done = 1'b0;
        while (!done) begin
            if (hs_out && !hs_q) begin
                if (cyc != 0) begin
                    check_value(cyc - hs_rise, m_h_total, "hs period");
                end
                hs_rise = cyc;
                hs_len  = 0;
            end
            if (hs_out) begin
                hs_len++;
            end
            if (!hs_out && hs_q) begin
                check_value(hs_len, m_h_sync, "hs width");
            end
            if (vs_out) begin
                vs_high++;
            end
            if (de_out) begin
                check_value(pixel, expect_pixel(px, py), "pixel");
                px++;
            end else begin
                check_value(pixel, 0, "pixel outside de");
                if (de_q) begin
                    check_value(px, m_aw, "de run length");
                    py++;
                    px = 0;
                end
            end
            hs_q = hs_out;
            de_q = de_out;
            vs_q = vs_out;
            @(negedge clk);
            cyc++;
            done = vs_out && !vs_q;
        end
        check_value(cyc, m_h_total * m_v_total, "vs period");
        check_value(vs_high, m_v_sync * m_h_total, "vs width");
        check_value(py, m_ah, "de lines per frame");
    endtask

    task automatic check_frame_count();
        logic [31:0] data;
        logic [1:0]  resp;
        int          diff;
        read_reg(reg_status, data, resp);
        check_value(resp, 2'b00, "status read response");
        diff = int'(data[15:0]) - vs_rises;
        if (diff > 1 || diff < -1) begin
            check_value(data[15:0], vs_rises, "frame count");
        end
    endtask

    task automatic run_timing_set(input int pat);
        write_okay(reg_ctrl, 32'h0);
        repeat (4) @(negedge clk);
        for (int i = 0; i < 60; i++) begin
            check_value({hs_out, vs_out, de_out}, 0, "sync or de while disabled");
            @(negedge clk);
        end
        m_h_sync  = pick_range(1, 4);
        m_h_bp    = pick_range(1, 4);
        m_h_fp    = pick_range(1, 4);
        m_h_total = pick_range(24, 48);
        m_v_sync  = pick_range(1, 4);
        m_v_bp    = pick_range(1, 4);
        m_v_fp    = pick_range(1, 4);
        m_v_total = pick_range(10, 20);
        if (m_v_total < m_v_sync + m_v_bp + m_v_fp + 2) begin
            m_v_total = m_v_sync + m_v_bp + m_v_fp + 2;  // At least two active lines
        end
        m_aw      = m_h_total - m_h_sync - m_h_bp - m_h_fp;
        m_ah      = m_v_total - m_v_sync - m_v_bp - m_v_fp;
        m_pattern = 3'(pat);
        m_arg     = 24'(next_rand());
        write_okay(reg_h_a, (m_h_total << 16) | m_h_sync);
        write_okay(reg_h_b, (m_h_bp << 16) | m_h_fp);
        write_okay(reg_v_a, (m_v_total << 16) | m_v_sync);
        write_okay(reg_v_b, (m_v_bp << 16) | m_v_fp);
        write_okay(reg_arg, {8'h00, m_arg});
        write_okay(reg_ctrl, (pat << 8) | 1);
        wait_vs_rise(1'b0, 1'b1);
        wait_vs_rise(1'b1, 1'b0);  // First frame skipped
        measure_frame();
        check_frame_count();
    endtask

    always @(negedge clk) begin
        if (vs_out && !vs_prev) begin
            vs_rises++;
        end
        vs_prev = vs_out;
    end

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Errors: %0d", errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_registers();
        for (int s = 0; s < num_sets; s++) begin
            run_timing_set(s);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/video_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module video_top import video_pkg::*; #(
    parameter int x_bits = 12,
    parameter int y_bits = 12
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [addr_bits-1:0]   awaddr,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire [31:0]            wdata,
    input  wire [3:0]             wstrb,
    input  wire                   wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  wire                   bready,
    input  wire [addr_bits-1:0]   araddr,
    input  wire                   arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  wire                   rready,
    output logic                  hs_out,
    output logic                  vs_out,
    output logic                  de_out,
    output logic [pixel_bits-1:0] pixel
);

    logic              enable;
    logic [x_bits-1:0] h_total;
    logic [x_bits-1:0] h_sync;
    logic [x_bits-1:0] h_bp;
    logic [x_bits-1:0] h_fp;
    logic [y_bits-1:0] v_total;
    logic [y_bits-1:0] v_sync;
    logic [y_bits-1:0] v_bp;
    logic [y_bits-1:0] v_fp;
    logic [2:0]        pattern;
    pattern_arg_t      pattern_arg;
    logic              frame_pulse;
    logic              hs;
    logic              vs;
    logic              de;
    logic [x_bits-1:0] x;
    logic [y_bits-1:0] y;
    logic [x_bits-1:0] active_width;
    logic [y_bits-1:0] active_height;

    video_regs #(.x_bits(x_bits), .y_bits(y_bits)) video_regs_inst (
        .clk         (clk),
        .reset       (reset),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .enable      (enable),
        .h_total     (h_total),
        .h_sync      (h_sync),
        .h_bp        (h_bp),
        .h_fp        (h_fp),
        .v_total     (v_total),
        .v_sync      (v_sync),
        .v_bp        (v_bp),
        .v_fp        (v_fp),
        .pattern     (pattern),
        .pattern_arg (pattern_arg),
        .frame_pulse (frame_pulse)
    );

    timing_gen #(.x_bits(x_bits), .y_bits(y_bits)) timing_gen_inst (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .h_total       (h_total),
        .h_sync        (h_sync),
        .h_bp          (h_bp),
        .h_fp          (h_fp),
        .v_total       (v_total),
        .v_sync        (v_sync),
        .v_bp          (v_bp),
        .v_fp          (v_fp),
        .hs            (hs),
        .vs            (vs),
        .de            (de),
        .x             (x),
        .y             (y),
        .active_width  (active_width),
        .active_height (active_height),
        .frame_pulse   (frame_pulse)
    );

    pattern_gen #(.x_bits(x_bits), .y_bits(y_bits)) pattern_gen_inst (
        .clk           (clk),
        .reset         (reset),
        .hs_in         (hs),
        .vs_in         (vs),
        .de_in         (de),
        .x             (x),
        .y             (y),
        .active_width  (active_width),
        .active_height (active_height),
        .pattern       (pattern),
        .pattern_arg   (pattern_arg),
        .hs_out        (hs_out),
        .vs_out        (vs_out),
        .de_out        (de_out),
        .pixel         (pixel)
    );

endmodule

`default_nettype wire

// ==== source/pattern_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module pattern_gen import video_pkg::*; #(
    parameter int x_bits = 12,
    parameter int y_bits = 12
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   hs_in,
    input  wire                   vs_in,
    input  wire                   de_in,
    input  wire [x_bits-1:0]      x,
    input  wire [y_bits-1:0]      y,
    input  wire [x_bits-1:0]      active_width,
    input  wire [y_bits-1:0]      active_height,
    input  wire [2:0]             pattern,
    input  wire pattern_arg_t     pattern_arg,
    output logic                  hs_out,
    output logic                  vs_out,
    output logic                  de_out,
    output logic [pixel_bits-1:0] pixel
);

    localparam int lane_bits = pixel_bits / 3;
    localparam logic [color_bits-1:0] white = '1;

    logic [color_bits+frac_bits-1:0] ramp_acc;
    logic [color_bits-1:0]           red;
    logic [color_bits-1:0]           green;
    logic [color_bits-1:0]           blue;
    logic                            edge_pix;

    assign edge_pix = (x == '0) || (y == '0) ||
                      (x == active_width - 1'b1) || (y == active_height - 1'b1);

    always_comb begin
        red   = '0;
        green = '0;
        blue  = '0;
        case (pattern)
            pat_solid: begin
                red   = pattern_arg.rgb.red;
                green = pattern_arg.rgb.green;
                blue  = pattern_arg.rgb.blue;
            end
            pat_border: begin
                red   = edge_pix ? white : '0;
                green = red;
                blue  = red;
            end
            pat_moire_x: begin
                red   = x[0] ? white : '0;  // Odd columns
                green = red;
                blue  = red;
            end
            pat_moire_y: begin
                red   = y[0] ? white : '0;  // Odd rows
                green = red;
                blue  = red;
            end
            pat_ramp: begin
                red   = ramp_acc[frac_bits +: color_bits];
                green = red;
                blue  = red;
            end
            default: ;  // Black
        endcase
    end

    // Ramp runs on every active pixel so it is in step when selected
    always_ff @(posedge clk) begin
        if (reset) begin
            ramp_acc <= '0;
        end else if (de_in) begin
            if (x == active_width - 1'b1) begin
                ramp_acc <= '0;
            end else if (x == '0) begin
                ramp_acc <= pattern_arg.ramp.step;
            end else begin
                ramp_acc <= ramp_acc + pattern_arg.ramp.step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hs_out <= 1'b0;
            vs_out <= 1'b0;
            de_out <= 1'b0;
        end else begin
            hs_out <= hs_in;  // Match the pixel register
            vs_out <= vs_in;
            de_out <= de_in;
        end
    end

    // Channel in the top of each lane, red highest
    always_ff @(posedge clk) begin
        if (!de_in) begin
            pixel <= '0;
        end else begin
            pixel <= {red,   {(lane_bits-color_bits){1'b0}},
                      green, {(lane_bits-color_bits){1'b0}},
                      blue,  {(lane_bits-color_bits){1'b0}}};
        end
    end

endmodule

`default_nettype wire

// ==== source/timing_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module timing_gen #(
    parameter int x_bits = 12,
    parameter int y_bits = 12
) (
    input  wire               clk,
    input  wire               reset,
    input  wire               enable,
    input  wire [x_bits-1:0]  h_total,
    input  wire [x_bits-1:0]  h_sync,
    input  wire [x_bits-1:0]  h_bp,
    input  wire [x_bits-1:0]  h_fp,
    input  wire [y_bits-1:0]  v_total,
    input  wire [y_bits-1:0]  v_sync,
    input  wire [y_bits-1:0]  v_bp,
    input  wire [y_bits-1:0]  v_fp,
    output logic              hs,
    output logic              vs,
    output logic              de,
    output logic [x_bits-1:0] x,
    output logic [y_bits-1:0] y,
    output logic [x_bits-1:0] active_width,
    output logic [y_bits-1:0] active_height,
    output logic              frame_pulse
);

    // Shadow copies, stable for a whole frame
    logic [x_bits-1:0] sh_h_total;
    logic [x_bits-1:0] sh_h_sync;
    logic [x_bits-1:0] sh_h_bp;
    logic [x_bits-1:0] sh_h_fp;
    logic [y_bits-1:0] sh_v_total;
    logic [y_bits-1:0] sh_v_sync;
    logic [y_bits-1:0] sh_v_bp;
    logic [y_bits-1:0] sh_v_fp;

    logic [x_bits-1:0] h_count;
    logic [y_bits-1:0] v_count;
    logic              enable_q;
    logic              run;
    logic              line_end;
    logic              frame_end;
    logic              h_active;
    logic              v_active;

    assign run       = enable && enable_q;  // Shadows are valid one cycle after the rise
    assign line_end  = (h_count == sh_h_total - 1'b1);
    assign frame_end = line_end && (v_count == sh_v_total - 1'b1);
    assign h_active  = (h_count >= sh_h_sync + sh_h_bp) && (h_count < sh_h_total - sh_h_fp);
    assign v_active  = (v_count >= sh_v_sync + sh_v_bp) && (v_count < sh_v_total - sh_v_fp);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q   <= 1'b0;
            sh_h_total <= '0;
            sh_h_sync  <= '0;
            sh_h_bp    <= '0;
            sh_h_fp    <= '0;
            sh_v_total <= '0;
            sh_v_sync  <= '0;
            sh_v_bp    <= '0;
            sh_v_fp    <= '0;
        end else begin
            enable_q <= enable;
            // Load on enable rise or at the last pixel of a frame
            if ((enable && !enable_q) || (run && frame_end)) begin
                sh_h_total <= h_total;
                sh_h_sync  <= h_sync;
                sh_h_bp    <= h_bp;
                sh_h_fp    <= h_fp;
                sh_v_total <= v_total;
                sh_v_sync  <= v_sync;
                sh_v_bp    <= v_bp;
                sh_v_fp    <= v_fp;
            end
        end
    end

    // Raster counters
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= frame_end ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hs          <= 1'b0;
            vs          <= 1'b0;
            de          <= 1'b0;
            frame_pulse <= 1'b0;
        end else begin
            hs          <= run && (h_count < sh_h_sync);
            vs          <= run && (v_count < sh_v_sync);
            de          <= run && h_active && v_active;
            frame_pulse <= run && (h_count == '0) && (v_count == '0);  // With the vs rise
        end
    end

    // Zero-based coordinates and the frame size for the pattern stage
    always_ff @(posedge clk) begin
        x             <= h_count - (sh_h_sync + sh_h_bp);
        y             <= v_count - (sh_v_sync + sh_v_bp);
        active_width  <= sh_h_total - (sh_h_sync + sh_h_bp + sh_h_fp);
        active_height <= sh_v_total - (sh_v_sync + sh_v_bp + sh_v_fp);
    end

endmodule

`default_nettype wire

// ==== source/video_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

module video_regs import video_pkg::*; #(
    parameter int x_bits = 12,
    parameter int y_bits = 12
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [addr_bits-1:0]  awaddr,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire [31:0]           wdata,
    input  wire [3:0]            wstrb,
    input  wire                  wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  wire                  bready,
    input  wire [addr_bits-1:0]  araddr,
    input  wire                  arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  wire                  rready,
    output logic                 enable,
    output logic [x_bits-1:0]    h_total,
    output logic [x_bits-1:0]    h_sync,
    output logic [x_bits-1:0]    h_bp,
    output logic [x_bits-1:0]    h_fp,
    output logic [y_bits-1:0]    v_total,
    output logic [y_bits-1:0]    v_sync,
    output logic [y_bits-1:0]    v_bp,
    output logic [y_bits-1:0]    v_fp,
    output logic [2:0]           pattern,
    output pattern_arg_t         pattern_arg,
    input  wire                  frame_pulse
);

    localparam int num_regs = (reg_arg >> 2) + 1;
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic [31:0] regs [0:num_regs-1];
    logic [15:0] frame_count;
    logic        wr_fire;
    logic        wr_reg;
    logic        wr_ok;
    logic        rd_fire;
    logic [31:0] rd_data;
    logic        rd_err;

    assign wr_fire = awready && awvalid && wvalid;
    assign wr_reg  = (awaddr[1:0] == 2'b00) && (awaddr <= reg_arg);
    assign wr_ok   = wr_reg || (awaddr == reg_status);  // Status writes are dropped
    assign rd_fire = arready && arvalid;
    assign wready  = awready;  // Address and data accepted together

    // Write channel
    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= resp_okay;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;  // One-cycle pulse
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? resp_okay : resp_slverr;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Register file with byte lanes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && wr_reg) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    regs[awaddr[4:2]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
        end else if (frame_pulse) begin
            frame_count <= frame_count + 16'd1;
        end
    end

    // Unmapped reads return zero
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        if ((araddr[1:0] == 2'b00) && (araddr <= reg_arg)) begin
            rd_data = regs[araddr[4:2]];
        end else if (araddr == reg_status) begin
            rd_data = {16'h0000, frame_count};
        end else begin
            rd_err = 1'b1;
        end
    end

    // Read channel
    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= resp_okay;
            rdata   <= '0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_data;
                rresp  <= rd_err ? resp_slverr : resp_okay;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    assign enable      = regs[reg_ctrl[4:2]][0];
    assign pattern     = regs[reg_ctrl[4:2]][10:8];
    assign h_total     = x_bits'(regs[reg_h_a[4:2]][27:16]);
    assign h_sync      = x_bits'(regs[reg_h_a[4:2]][11:0]);
    assign h_bp        = x_bits'(regs[reg_h_b[4:2]][27:16]);
    assign h_fp        = x_bits'(regs[reg_h_b[4:2]][11:0]);
    assign v_total     = y_bits'(regs[reg_v_a[4:2]][27:16]);
    assign v_sync      = y_bits'(regs[reg_v_a[4:2]][11:0]);
    assign v_bp        = y_bits'(regs[reg_v_b[4:2]][27:16]);
    assign v_fp        = y_bits'(regs[reg_v_b[4:2]][11:0]);
    assign pattern_arg = regs[reg_arg[4:2]][23:0];

endmodule

`default_nettype wire

// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

    localparam int color_bits = 8;   // Bits per colour channel
    localparam int frac_bits  = 12;  // Ramp accumulator fraction
    localparam int pixel_bits = 36;  // Three 12-bit transmitter lanes
    localparam int addr_bits  = 8;

    // Register map, byte addresses
    localparam logic [addr_bits-1:0] reg_ctrl   = 8'h00;  // Enable and pattern code
    localparam logic [addr_bits-1:0] reg_h_a    = 8'h04;  // h_total, h_sync
    localparam logic [addr_bits-1:0] reg_h_b    = 8'h08;  // h_bp, h_fp
    localparam logic [addr_bits-1:0] reg_v_a    = 8'h0C;  // v_total, v_sync
    localparam logic [addr_bits-1:0] reg_v_b    = 8'h10;  // v_bp, v_fp
    localparam logic [addr_bits-1:0] reg_arg    = 8'h14;  // Pattern argument
    localparam logic [addr_bits-1:0] reg_status = 8'h18;  // Frame count, read only

    // Pattern codes, anything else is black
    localparam logic [2:0] pat_solid   = 3'd0;
    localparam logic [2:0] pat_border  = 3'd1;
    localparam logic [2:0] pat_moire_x = 3'd2;
    localparam logic [2:0] pat_moire_y = 3'd3;
    localparam logic [2:0] pat_ramp    = 3'd4;

    // Argument word is a ramp step or a solid colour
    typedef union packed {
        struct packed {
            logic [3:0]                     pad;
            logic [color_bits+frac_bits-1:0] step;
        } ramp;
        struct packed {
            logic [color_bits-1:0] red;
            logic [color_bits-1:0] green;
            logic [color_bits-1:0] blue;
        } rgb;
    } pattern_arg_t;

endpackage

`default_nettype wire
